//--- dp_macros.svh
// Packet datapath global sizes
// Stream width, buffer depths, port count, reset hold and counter width
`ifndef DP_MACROS_SVH
`define DP_MACROS_SVH

// Stream word width in bits
`define DP_DATA_W 32

// Two network ports plus the host DMA port
`define DP_NUM_PORTS 3

// Buffer depths in words
`define DP_IN_DEPTH 8
`define DP_OUT_DEPTH 16

// Core reset hold after the external reset falls, in core_clk cycles
`define DP_RESET_HOLD 16

// Per-output frame counter width
`define DP_CNT_W 16

`endif

//--- dp_pkg.sv
// Packet datapath types
// Port numbers, destination masks and the FIFO beat layouts
`include "dp_macros.svh"

package dp_pkg;

  // Port number, also the source tag carried with each beat
  typedef logic [1:0] port_id_t;

  localparam port_id_t PORT_NET0 = 2'd0;
  localparam port_id_t PORT_NET1 = 2'd1;
  localparam port_id_t PORT_DMA  = 2'd2;

  // One-hot destination, bit n selects port n
  typedef logic [`DP_NUM_PORTS-1:0] dst_mask_t;

  // Input buffer beat
  typedef struct packed {
    logic [`DP_DATA_W-1:0] data;
    logic                  last;
  } in_beat_t;

  // Output buffer beat, keeps the source tag
  typedef struct packed {
    logic [`DP_DATA_W-1:0] data;
    logic                  last;
    port_id_t              src;
  } out_beat_t;

endpackage

//--- reset_sequencer.sv
// Core reset sequencer
// Keeps core_rst asserted for a fixed number of core_clk cycles
// after the external reset is released
`include "dp_macros.svh"
`timescale 1ns/1ps

module reset_sequencer (
  input  logic core_clk,
  input  logic reset,
  output logic core_rst
);

  localparam int hold_w = $clog2(`DP_RESET_HOLD + 1);

  logic [hold_w-1:0] hold_cnt;

  always_ff @(posedge core_clk) begin
    if (reset) begin
      hold_cnt <= '0;
      core_rst <= 1'b1;
    end else if (hold_cnt != hold_w'(`DP_RESET_HOLD)) begin
      hold_cnt <= hold_cnt + 1'b1;
      core_rst <= 1'b1;
    end else begin
      // Count reached, release on this edge
      core_rst <= 1'b0;
    end
  end

endmodule

//--- stream_fifo.sv
// Show-ahead stream FIFO
// Circular buffer with valid/ready on both sides. The head word is
// presented on out_data as soon as it is stored
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 8
) (
  input  logic     core_clk,
  input  logic     core_rst,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] count_next;
  logic             wr_en;
  logic             rd_en;

  assign wr_en      = in_valid && in_ready;
  assign rd_en      = out_valid && out_ready;
  assign count_next = count + cnt_w'(wr_en) - cnt_w'(rd_en);

  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  always_ff @(posedge core_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge core_clk) begin
    if (core_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_next;
      // Ready is registered from the next fill level
      in_ready <= (count_next != cnt_w'(depth));
    end
  end

  a_no_write_when_full : assert property (
    @(posedge core_clk) disable iff (core_rst)
    wr_en |-> (count != cnt_w'(depth))
  ) else $error("stream_fifo accepted a write while full");

endmodule

//--- input_arbiter.sv
// Input arbiter
// Buffers the two network receive streams and the DMA stream, then
// merges them one frame at a time in round-robin order. Each beat
// leaves tagged with the port it came from
`include "dp_macros.svh"
`timescale 1ns/1ps

module input_arbiter
  import dp_pkg::*;
(
  input  logic                  core_clk,
  input  logic                  core_rst,
  input  logic [`DP_DATA_W-1:0] rx0_data,
  input  logic                  rx0_last,
  input  logic                  rx0_valid,
  output logic                  rx0_ready,
  input  logic [`DP_DATA_W-1:0] rx1_data,
  input  logic                  rx1_last,
  input  logic                  rx1_valid,
  output logic                  rx1_ready,
  input  logic [`DP_DATA_W-1:0] dma_in_data,
  input  logic                  dma_in_last,
  input  logic                  dma_in_valid,
  output logic                  dma_in_ready,
  output logic [`DP_DATA_W-1:0] arb_data,
  output logic                  arb_last,
  output port_id_t              arb_src,
  output logic                  arb_valid,
  input  logic                  arb_ready
);

  in_beat_t                 fifo_in  [`DP_NUM_PORTS];
  in_beat_t                 fifo_out [`DP_NUM_PORTS];
  logic [`DP_NUM_PORTS-1:0] rx_valid;
  logic [`DP_NUM_PORTS-1:0] rx_ready;
  logic [`DP_NUM_PORTS-1:0] fifo_valid;
  logic [`DP_NUM_PORTS-1:0] fifo_ready;
  logic [`DP_NUM_PORTS-1:0] grant_q;
  logic [`DP_NUM_PORTS-1:0] next_grant;
  logic                     busy_q;
  port_id_t                 sel;

  assign fifo_in[PORT_NET0] = '{data: rx0_data, last: rx0_last};
  assign fifo_in[PORT_NET1] = '{data: rx1_data, last: rx1_last};
  assign fifo_in[PORT_DMA]  = '{data: dma_in_data, last: dma_in_last};

  assign rx_valid = {dma_in_valid, rx1_valid, rx0_valid};
  assign {dma_in_ready, rx1_ready, rx0_ready} = rx_ready;

  for (genvar i = 0; i < `DP_NUM_PORTS; i++) begin : g_in_fifo
    stream_fifo #(
      .payload_t (in_beat_t),
      .depth     (`DP_IN_DEPTH)
    ) in_fifo_i (
      .core_clk  (core_clk),
      .core_rst  (core_rst),
      .in_data   (fifo_in[i]),
      .in_valid  (rx_valid[i]),
      .in_ready  (rx_ready[i]),
      .out_data  (fifo_out[i]),
      .out_valid (fifo_valid[i]),
      .out_ready (fifo_ready[i])
    );

    // Only the granted buffer drains
    assign fifo_ready[i] = busy_q && grant_q[i] && arb_ready;
  end

  // ----------------------------------------------------------
  // Round-robin grant, changed only between frames
  // ----------------------------------------------------------
  always_comb begin
    sel = PORT_NET0;
    if (grant_q[PORT_NET1]) sel = PORT_NET1;
    if (grant_q[PORT_DMA]) sel = PORT_DMA;
  end

  // Walk down so the port closest after the last grant wins
  always_comb begin
    int idx;
    next_grant = '0;
    for (int i = `DP_NUM_PORTS; i >= 1; i--) begin
      idx = (int'(sel) + i) % `DP_NUM_PORTS;
      if (fifo_valid[idx]) begin
        next_grant = {{(`DP_NUM_PORTS-1){1'b0}}, 1'b1} << idx;
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (core_rst) begin
      // Start as if DMA went last so port 0 is served first
      grant_q <= {1'b1, {(`DP_NUM_PORTS-1){1'b0}}};
      busy_q  <= 1'b0;
    end else if (!busy_q) begin
      if (|fifo_valid) begin
        grant_q <= next_grant;
        busy_q  <= 1'b1;
      end
    end else if (arb_valid && arb_ready && arb_last) begin
      busy_q <= 1'b0;
    end
  end

  assign arb_data  = fifo_out[sel].data;
  assign arb_last  = fifo_out[sel].last;
  assign arb_src   = sel;
  assign arb_valid = busy_q && fifo_valid[sel];

  a_grant_onehot : assert property (
    @(posedge core_clk) disable iff (core_rst)
    busy_q |-> $onehot(grant_q)
  ) else $error("input_arbiter grant not one-hot during a frame");

endmodule

//--- output_port_lookup.sv
// Output port lookup
// One register stage that picks a destination on the first beat of
// each frame and keeps it for the rest of the frame
`include "dp_macros.svh"
`timescale 1ns/1ps

module output_port_lookup
  import dp_pkg::*;
(
  input  logic                  core_clk,
  input  logic                  core_rst,
  input  logic [`DP_DATA_W-1:0] arb_data,
  input  logic                  arb_last,
  input  port_id_t              arb_src,
  input  logic                  arb_valid,
  output logic                  arb_ready,
  output logic [`DP_DATA_W-1:0] lk_data,
  output logic                  lk_last,
  output port_id_t              lk_src,
  output dst_mask_t             lk_dst,
  output logic                  lk_valid,
  input  logic                  lk_ready
);

  logic      sof_q;
  logic      accept;
  dst_mask_t first_dst;

  // Stage is empty or empties this cycle
  assign arb_ready = !lk_valid || lk_ready;
  assign accept    = arb_valid && arb_ready;

  // Network traffic goes to the host, host traffic steers on bit 0
  always_comb begin
    if (arb_src == PORT_DMA) begin
      first_dst = dst_mask_t'(1) << (arb_data[0] ? PORT_NET1 : PORT_NET0);
    end else begin
      first_dst = dst_mask_t'(1) << PORT_DMA;
    end
  end

  always_ff @(posedge core_clk) begin
    if (core_rst) begin
      lk_valid <= 1'b0;
      sof_q    <= 1'b1;
    end else begin
      if (arb_ready) lk_valid <= arb_valid;
      if (accept) sof_q <= arb_last;
    end
  end

  always_ff @(posedge core_clk) begin
    if (accept) begin
      lk_data <= arb_data;
      lk_last <= arb_last;
      lk_src  <= arb_src;
      if (sof_q) lk_dst <= first_dst;
    end
  end

endmodule

//--- output_queues.sv
// Output queues
// Steers each beat into the buffer of its destination, counts frames
// leaving each output and answers counter reads over a req/ack handshake
`include "dp_macros.svh"
`timescale 1ns/1ps

module output_queues
  import dp_pkg::*;
(
  input  logic                  core_clk,
  input  logic                  core_rst,
  input  logic [`DP_DATA_W-1:0] lk_data,
  input  logic                  lk_last,
  input  port_id_t              lk_src,
  input  dst_mask_t             lk_dst,
  input  logic                  lk_valid,
  output logic                  lk_ready,
  output logic [`DP_DATA_W-1:0] tx0_data,
  output logic                  tx0_last,
  output logic                  tx0_valid,
  input  logic                  tx0_ready,
  output logic [`DP_DATA_W-1:0] tx1_data,
  output logic                  tx1_last,
  output logic                  tx1_valid,
  input  logic                  tx1_ready,
  output logic [`DP_DATA_W-1:0] dma_out_data,
  output logic                  dma_out_last,
  output logic                  dma_out_valid,
  input  logic                  dma_out_ready,
  output port_id_t              dma_out_src,
  input  logic                  cnt_req,
  input  port_id_t              cnt_addr,
  output logic                  cnt_ack,
  output logic [`DP_CNT_W-1:0]  cnt_data
);

  out_beat_t                fifo_in;
  out_beat_t                fifo_out [`DP_NUM_PORTS];
  logic [`DP_NUM_PORTS-1:0] wr_valid;
  logic [`DP_NUM_PORTS-1:0] wr_ready;
  logic [`DP_NUM_PORTS-1:0] out_valid;
  logic [`DP_NUM_PORTS-1:0] out_ready;
  logic [`DP_CNT_W-1:0]     frame_cnt [`DP_NUM_PORTS];

  assign fifo_in  = '{data: lk_data, last: lk_last, src: lk_src};
  assign wr_valid = lk_dst & {`DP_NUM_PORTS{lk_valid}};
  // A full destination stalls the whole pipeline
  assign lk_ready = |(lk_dst & wr_ready);

  assign out_ready = {dma_out_ready, tx1_ready, tx0_ready};

  for (genvar i = 0; i < `DP_NUM_PORTS; i++) begin : g_out_fifo
    stream_fifo #(
      .payload_t (out_beat_t),
      .depth     (`DP_OUT_DEPTH)
    ) out_fifo_i (
      .core_clk  (core_clk),
      .core_rst  (core_rst),
      .in_data   (fifo_in),
      .in_valid  (wr_valid[i]),
      .in_ready  (wr_ready[i]),
      .out_data  (fifo_out[i]),
      .out_valid (out_valid[i]),
      .out_ready (out_ready[i])
    );

    // Frame counted when its last beat leaves
    always_ff @(posedge core_clk) begin
      if (core_rst) begin
        frame_cnt[i] <= '0;
      end else if (out_valid[i] && out_ready[i] && fifo_out[i].last) begin
        frame_cnt[i] <= frame_cnt[i] + 1'b1;
      end
    end
  end

  assign tx0_data      = fifo_out[PORT_NET0].data;
  assign tx0_last      = fifo_out[PORT_NET0].last;
  assign tx0_valid     = out_valid[PORT_NET0];
  assign tx1_data      = fifo_out[PORT_NET1].data;
  assign tx1_last      = fifo_out[PORT_NET1].last;
  assign tx1_valid     = out_valid[PORT_NET1];
  assign dma_out_data  = fifo_out[PORT_DMA].data;
  assign dma_out_last  = fifo_out[PORT_DMA].last;
  assign dma_out_valid = out_valid[PORT_DMA];
  assign dma_out_src   = fifo_out[PORT_DMA].src;

  // ----------------------------------------------------------
  // Four-phase req/ack counter reads
  // ----------------------------------------------------------
  always_ff @(posedge core_clk) begin
    if (core_rst) cnt_ack <= 1'b0;
    else cnt_ack <= cnt_req;
  end

  // Sampled once per request and held through the ack phase
  always_ff @(posedge core_clk) begin
    if (cnt_req && !cnt_ack) begin
      cnt_data <= (cnt_addr < `DP_NUM_PORTS) ? frame_cnt[cnt_addr] : '0;
    end
  end

  a_dst_onehot : assert property (
    @(posedge core_clk) disable iff (core_rst)
    lk_valid |-> $onehot(lk_dst)
  ) else $error("output_queues got a beat without a one-hot destination");

  a_ack_needs_req : assert property (
    @(posedge core_clk) disable iff (core_rst)
    $rose(cnt_ack) |-> $past(cnt_req)
  ) else $error("cnt_ack rose while cnt_req was low");

endmodule

//--- dp_top.sv
// Three-port packet datapath top level
// Reset sequencer, input arbiter, output port lookup and output queues
// between two network ports and the host DMA port
`include "dp_macros.svh"
`timescale 1ns/1ps

module dp_top
  import dp_pkg::*;
(
  input  logic                  core_clk,
  input  logic                  reset,
  input  logic [`DP_DATA_W-1:0] rx0_data,
  input  logic                  rx0_last,
  input  logic                  rx0_valid,
  output logic                  rx0_ready,
  input  logic [`DP_DATA_W-1:0] rx1_data,
  input  logic                  rx1_last,
  input  logic                  rx1_valid,
  output logic                  rx1_ready,
  input  logic [`DP_DATA_W-1:0] dma_in_data,
  input  logic                  dma_in_last,
  input  logic                  dma_in_valid,
  output logic                  dma_in_ready,
  output logic [`DP_DATA_W-1:0] tx0_data,
  output logic                  tx0_last,
  output logic                  tx0_valid,
  input  logic                  tx0_ready,
  output logic [`DP_DATA_W-1:0] tx1_data,
  output logic                  tx1_last,
  output logic                  tx1_valid,
  input  logic                  tx1_ready,
  output logic [`DP_DATA_W-1:0] dma_out_data,
  output logic                  dma_out_last,
  output logic                  dma_out_valid,
  input  logic                  dma_out_ready,
  output port_id_t              dma_out_src,
  input  logic                  cnt_req,
  input  port_id_t              cnt_addr,
  output logic                  cnt_ack,
  output logic [`DP_CNT_W-1:0]  cnt_data
);

  logic                  core_rst;

  // Arbiter to lookup
  logic [`DP_DATA_W-1:0] arb_data;
  logic                  arb_last;
  port_id_t              arb_src;
  logic                  arb_valid;
  logic                  arb_ready;

  // Lookup to output queues
  logic [`DP_DATA_W-1:0] lk_data;
  logic                  lk_last;
  port_id_t              lk_src;
  dst_mask_t             lk_dst;
  logic                  lk_valid;
  logic                  lk_ready;

  reset_sequencer reset_sequencer_i (
    .core_clk (core_clk),
    .reset    (reset),
    .core_rst (core_rst)
  );

  input_arbiter input_arbiter_i (
    .core_clk     (core_clk),
    .core_rst     (core_rst),
    .rx0_data     (rx0_data),
    .rx0_last     (rx0_last),
    .rx0_valid    (rx0_valid),
    .rx0_ready    (rx0_ready),
    .rx1_data     (rx1_data),
    .rx1_last     (rx1_last),
    .rx1_valid    (rx1_valid),
    .rx1_ready    (rx1_ready),
    .dma_in_data  (dma_in_data),
    .dma_in_last  (dma_in_last),
    .dma_in_valid (dma_in_valid),
    .dma_in_ready (dma_in_ready),
    .arb_data     (arb_data),
    .arb_last     (arb_last),
    .arb_src      (arb_src),
    .arb_valid    (arb_valid),
    .arb_ready    (arb_ready)
  );

  output_port_lookup output_port_lookup_i (
    .core_clk  (core_clk),
    .core_rst  (core_rst),
    .arb_data  (arb_data),
    .arb_last  (arb_last),
    .arb_src   (arb_src),
    .arb_valid (arb_valid),
    .arb_ready (arb_ready),
    .lk_data   (lk_data),
    .lk_last   (lk_last),
    .lk_src    (lk_src),
    .lk_dst    (lk_dst),
    .lk_valid  (lk_valid),
    .lk_ready  (lk_ready)
  );

  output_queues output_queues_i (
    .core_clk      (core_clk),
    .core_rst      (core_rst),
    .lk_data       (lk_data),
    .lk_last       (lk_last),
    .lk_src        (lk_src),
    .lk_dst        (lk_dst),
    .lk_valid      (lk_valid),
    .lk_ready      (lk_ready),
    .tx0_data      (tx0_data),
    .tx0_last      (tx0_last),
    .tx0_valid     (tx0_valid),
    .tx0_ready     (tx0_ready),
    .tx1_data      (tx1_data),
    .tx1_last      (tx1_last),
    .tx1_valid     (tx1_valid),
    .tx1_ready     (tx1_ready),
    .dma_out_data  (dma_out_data),
    .dma_out_last  (dma_out_last),
    .dma_out_valid (dma_out_valid),
    .dma_out_ready (dma_out_ready),
    .dma_out_src   (dma_out_src),
    .cnt_req       (cnt_req),
    .cnt_addr      (cnt_addr),
    .cnt_ack       (cnt_ack),
    .cnt_data      (cnt_data)
  );

endmodule

//--- tb_dp_top.sv
// Testbench for the three-port packet datapath
// LFSR-driven frames on rx0, rx1 and dma_in, random output ready,
// expected-word queues per output checked by concurrent assertions,
// and counter reads over the req/ack handshake
`include "dp_macros.svh"
`timescale 1ns/1ps

module tb_dp_top
  import dp_pkg::*;
();

  logic                  core_clk;
  logic                  reset;
  // Input streams indexed rx0, rx1, dma_in
  logic [2:0]            vld;
  logic [2:0]            lst;
  logic [`DP_DATA_W-1:0] dat [3];
  logic [2:0]            rdy_in;
  // Output ready indexed tx0, tx1, dma_out
  logic [2:0]            out_rdy;
  logic [`DP_DATA_W-1:0] tx0_data;
  logic                  tx0_last;
  logic                  tx0_valid;
  logic [`DP_DATA_W-1:0] tx1_data;
  logic                  tx1_last;
  logic                  tx1_valid;
  logic [`DP_DATA_W-1:0] dma_out_data;
  logic                  dma_out_last;
  logic                  dma_out_valid;
  port_id_t              dma_out_src;
  logic                  cnt_req;
  port_id_t              cnt_addr;
  logic                  cnt_ack;
  logic [`DP_CNT_W-1:0]  cnt_data;

  logic [31:0]           lfsr;
  logic [2:0]            took;
  logic [2:0]            sent;
  port_id_t              sent_dma_src;
  logic                  sent_dma_last;
  int                    remaining [3];
  int                    beat_idx [3];
  int                    frame_len [3];
  int                    gap [3];
  logic [13:0]           seq [3];
  logic                  dma_steer;
  // Expected words for tx0, tx1, dma from rx0 and dma from rx1
  logic [32:0]           exp_q [4][$];
  logic [32:0]           head [4];
  logic [3:0]            have;
  logic [32:0]           dma_head;
  logic                  dma_have;
  int                    exp_frames [3];
  logic [`DP_CNT_W-1:0]  exp_cnt;
  int                    errors;
  int                    words_sent;
  int                    frames_sent;
  int                    cycles;
  int                    rel_cnt = 0;
  logic                  clk_seen = 1'b0;
  logic                  started = 1'b0;
  logic                  dma_mid;
  logic                  rand_ready;
  port_id_t              dma_frame_src;
  string                 test_name;

  dp_top dp_top_i (
    .core_clk      (core_clk),
    .reset         (reset),
    .rx0_data      (dat[0]),
    .rx0_last      (lst[0]),
    .rx0_valid     (vld[0]),
    .rx0_ready     (rdy_in[0]),
    .rx1_data      (dat[1]),
    .rx1_last      (lst[1]),
    .rx1_valid     (vld[1]),
    .rx1_ready     (rdy_in[1]),
    .dma_in_data   (dat[2]),
    .dma_in_last   (lst[2]),
    .dma_in_valid  (vld[2]),
    .dma_in_ready  (rdy_in[2]),
    .tx0_data      (tx0_data),
    .tx0_last      (tx0_last),
    .tx0_valid     (tx0_valid),
    .tx0_ready     (out_rdy[0]),
    .tx1_data      (tx1_data),
    .tx1_last      (tx1_last),
    .tx1_valid     (tx1_valid),
    .tx1_ready     (out_rdy[1]),
    .dma_out_data  (dma_out_data),
    .dma_out_last  (dma_out_last),
    .dma_out_valid (dma_out_valid),
    .dma_out_ready (out_rdy[2]),
    .dma_out_src   (dma_out_src),
    .cnt_req       (cnt_req),
    .cnt_addr      (cnt_addr),
    .cnt_ack       (cnt_ack),
    .cnt_data      (cnt_data)
  );

  initial begin
    core_clk = 1'b0;
    forever #5 core_clk = ~core_clk;
  end

  assign dma_head = (dma_out_src == 2'd1) ? head[3] : head[2];
  assign dma_have = (dma_out_src == 2'd1) ? have[3] : have[2];

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h8020_0003;
    return n;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [15:0] draw(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[14:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return r;
  endfunction

  function automatic void update_heads();
    for (int i = 0; i < 4; i++) begin
      have[i] = (exp_q[i].size() != 0);
      head[i] = have[i] ? exp_q[i][0] : '0;
    end
  endfunction

  function automatic logic idle();
    return (remaining[0] == 0) && (remaining[1] == 0) && (remaining[2] == 0) &&
           (vld == 3'b000) && (have == 4'b0000);
  endfunction

  task automatic check_fail(input string what, input logic [32:0] exp, input logic [32:0] act);
    errors++;
    $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Failure in %s: %s", test_name, what);
  endtask

  task automatic drop_head(input int i);
    if (exp_q[i].size() != 0) void'(exp_q[i].pop_front());
    update_heads();
  endtask

  // Each word holds its source in bits 31 to 30 and a sequence number below
  task automatic make_beat(input int p);
    int dst;
    if (beat_idx[p] == 0) frame_len[p] = int'(draw(2)) + 1;
    dat[p] = {2'(p), seq[p], draw(16)};
    if (beat_idx[p] == 0 && p == PORT_DMA) dma_steer = dat[p][0];
    seq[p]++;
    lst[p] = (beat_idx[p] + 1 == frame_len[p]);
    vld[p] = 1'b1;
    dst = (p == PORT_DMA) ? (dma_steer ? 1 : 0) : p + 2;
    exp_q[dst].push_back({lst[p], dat[p]});
    update_heads();
    words_sent++;
    if (lst[p]) begin
      if (p == PORT_DMA) exp_frames[dst]++;
      else exp_frames[PORT_DMA]++;
      frames_sent++;
      beat_idx[p] = 0;
      gap[p] = int'(draw(2));
    end else begin
      beat_idx[p]++;
    end
  endtask

  // Runs at each falling edge while traffic is active
  task automatic tick();
    if (sent[0]) drop_head(0);
    if (sent[1]) drop_head(1);
    if (sent[2]) begin
      drop_head((sent_dma_src == 2'd1) ? 3 : 2);
      dma_mid = !sent_dma_last;
      dma_frame_src = sent_dma_src;
    end
    for (int p = 0; p < 3; p++) begin
      if (vld[p] && took[p]) begin
        vld[p] = 1'b0;
        if (lst[p]) remaining[p]--;
      end
      if (!vld[p] && remaining[p] > 0) begin
        if (gap[p] > 0) gap[p]--;
        else make_beat(p);
      end
    end
    out_rdy = rand_ready ? 3'(draw(3)) : 3'b111;
  endtask

  task automatic run_traffic(input string name, input int n0, input int n1, input int n2,
                             input logic rr);
    test_name = name;
    rand_ready = rr;
    remaining[0] = n0;
    remaining[1] = n1;
    remaining[2] = n2;
    do begin
      @(negedge core_clk);
      tick();
    end while (!idle());
  endtask

  task automatic read_counter(input port_id_t addr, input int expected);
    @(negedge core_clk);
    exp_cnt = expected[`DP_CNT_W-1:0];
    cnt_addr = addr;
    cnt_req = 1'b1;
    do @(negedge core_clk); while (!cnt_ack);
    cnt_req = 1'b0;
    do @(negedge core_clk); while (cnt_ack);
  endtask

  task automatic close_run();
    $display("Summary: %0d errors, %0d words and %0d frames sent",
             errors, words_sent, frames_sent);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // Handshakes seen at the rising edge and consumed at the next falling edge
  always @(posedge core_clk) begin
    took          <= vld & rdy_in;
    sent          <= {dma_out_valid & out_rdy[2], tx1_valid & out_rdy[1],
                      tx0_valid & out_rdy[0]};
    sent_dma_src  <= dma_out_src;
    sent_dma_last <= dma_out_last;
    // Core reset reaches every register by the second edge
    clk_seen      <= 1'b1;
    started       <= clk_seen;
    if (reset) rel_cnt <= 0;
    else if (rel_cnt < 1000) rel_cnt <= rel_cnt + 1;
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  a_reset_quiet : assert property (@(posedge core_clk)
    (started && (reset || rel_cnt < `DP_RESET_HOLD)) |->
    !(tx0_valid || tx1_valid || dma_out_valid || cnt_ack || (|rdy_in))
  ) else report_failure("outputs became active while the core reset was held");

  a_tx0_expected : assert property (@(posedge core_clk) disable iff (reset)
    (tx0_valid && out_rdy[0]) |-> have[0]
  ) else report_failure("tx0 sent a beat that was not expected");
  a_tx0_beat : assert property (@(posedge core_clk) disable iff (reset)
    (tx0_valid && out_rdy[0] && have[0]) |-> ({tx0_last, tx0_data} == head[0])
  ) else check_fail("tx0 beat", $sampled(head[0]), $sampled({tx0_last, tx0_data}));

  a_tx1_expected : assert property (@(posedge core_clk) disable iff (reset)
    (tx1_valid && out_rdy[1]) |-> have[1]
  ) else report_failure("tx1 sent a beat that was not expected");
  a_tx1_beat : assert property (@(posedge core_clk) disable iff (reset)
    (tx1_valid && out_rdy[1] && have[1]) |-> ({tx1_last, tx1_data} == head[1])
  ) else check_fail("tx1 beat", $sampled(head[1]), $sampled({tx1_last, tx1_data}));

  a_dma_expected : assert property (@(posedge core_clk) disable iff (reset)
    (dma_out_valid && out_rdy[2]) |-> dma_have
  ) else report_failure("dma_out sent a beat that was not expected");
  a_dma_beat : assert property (@(posedge core_clk) disable iff (reset)
    (dma_out_valid && out_rdy[2] && dma_have) |-> ({dma_out_last, dma_out_data} == dma_head)
  ) else check_fail("dma_out beat", $sampled(dma_head),
                    $sampled({dma_out_last, dma_out_data}));
  a_dma_src : assert property (@(posedge core_clk) disable iff (reset)
    dma_out_valid |-> (dma_out_src == dma_out_data[31:30])
  ) else check_fail("dma_out_src", $sampled(dma_out_data[31:30]), $sampled(dma_out_src));
  a_dma_unbroken : assert property (@(posedge core_clk) disable iff (reset)
    (dma_out_valid && dma_mid) |-> (dma_out_src == dma_frame_src)
  ) else report_failure("dma_out frame was interleaved with another source");

  a_cnt_data : assert property (@(posedge core_clk) disable iff (reset)
    cnt_ack |-> (cnt_data == exp_cnt)
  ) else check_fail("cnt_data", $sampled(exp_cnt), $sampled(cnt_data));
  a_ack_rise : assert property (@(posedge core_clk) disable iff (reset)
    cnt_req |=> cnt_ack
  ) else report_failure("cnt_ack was not high one cycle after cnt_req");
  a_ack_fall : assert property (@(posedge core_clk) disable iff (reset)
    !cnt_req |=> !cnt_ack
  ) else report_failure("cnt_ack stayed high after cnt_req fell");

  // ----------------------------------------------------------
  // Timeout and main sequence
  // ----------------------------------------------------------
  initial begin : watchdog
    cycles = 0;
    while (cycles <= 40 * words_sent + 200) begin
      @(posedge core_clk);
      cycles++;
    end
    errors++;
    $display("Timeout: the run did not complete within %0d cycles", cycles);
    close_run();
  end

  initial begin
    reset = 1'b1;
    vld = '0;
    lst = '0;
    out_rdy = 3'b111;
    cnt_req = 1'b0;
    cnt_addr = '0;
    exp_cnt = '0;
    lfsr = 32'h1a34;
    errors = 0;
    words_sent = 0;
    frames_sent = 0;
    rand_ready = 1'b0;
    dma_mid = 1'b0;
    dma_steer = 1'b0;
    dma_frame_src = '0;
    test_name = "reset";
    for (int p = 0; p < 3; p++) begin
      dat[p] = '0;
      remaining[p] = 0;
      beat_idx[p] = 0;
      frame_len[p] = 1;
      gap[p] = 0;
      seq[p] = '0;
      exp_frames[p] = 0;
    end
    update_heads();
    repeat (10) @(posedge core_clk);
    @(negedge core_clk);
    reset = 1'b0;
    repeat (`DP_RESET_HOLD + 4) @(negedge core_clk);

    run_traffic("net_to_dma", 6, 6, 0, 1'b0);
    run_traffic("dma_steering", 0, 0, 8, 1'b0);
    run_traffic("backpressure", 8, 8, 8, 1'b1);

    test_name = "counter_reads";
    out_rdy = 3'b111;
    for (int i = 0; i < 3; i++) begin
      read_counter(port_id_t'(i), exp_frames[i]);
    end
    read_counter(2'd3, 0);
    repeat (4) @(negedge core_clk);
    close_run();
  end

endmodule

//--- vlog.f
+incdir+.
dp_pkg.sv
reset_sequencer.sv
stream_fifo.sv
input_arbiter.sv
output_port_lookup.sv
output_queues.sv
dp_top.sv
tb_dp_top.sv

//--- Bender.yml
package:
  name: dp_top

sources:
  - include_dirs:
      - .
    files:
      - dp_pkg.sv
      - reset_sequencer.sv
      - stream_fifo.sv
      - input_arbiter.sv
      - output_port_lookup.sv
      - output_queues.sv
      - dp_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dp_top.sv
